/* icache_config.svh */
/*
 * Instruction cache configuration
 *   address split widths (tag, index, byte offset, word select)
 *   line and word sizes
 *   main set count and victim buffer depth
 */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// address split
`define ICACHE_TAG_W        20
`define ICACHE_INDEX_W      6
`define ICACHE_OFFSET_W     6
`define ICACHE_WORD_SEL_W   4

// data sizes
`define ICACHE_LINE_W       512
`define ICACHE_WORD_W       32

// storage depths
`define ICACHE_SETS         64
`define ICACHE_VICTIM_DEPTH 4

`endif

/* icache_addr_pkg.sv */
/*
 * Address and data vector types for the instruction cache
 *   tag, index, word select
 *   line address used by the victim buffer and memory
 *   line, word and full fetch address
 */
`include "icache_config.svh"

package icache_addr_pkg;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    typedef logic [`ICACHE_WORD_SEL_W-1:0] word_sel_t;

    // tag in the upper bits, index in the lower bits
    typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W-1:0] line_addr_t;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    // byte address as issued by the CPU
    typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0] fetch_addr_t;

endpackage

/* icache_pipe_pkg.sv */
/*
 * Pipeline types for the instruction cache
 *   fetch_req_t   request carried through stages one and two
 *   array_rd_t    registered read of one main set
 *   miss_state_t  miss, evict and refill FSM states
 */
`include "icache_config.svh"

package icache_pipe_pkg;

    import icache_addr_pkg::*;

    // line address plus the word wanted inside the line
    typedef struct packed {
        line_addr_t line_addr;
        word_sel_t  word_sel;
    } fetch_req_t;

    // one set of the main store
    typedef struct packed {
        tag_t  tag;
        logic  valid;
        line_t line;
    } array_rd_t;

    // replay is the re-lookup after a fill
    typedef enum logic [2:0] {
        miss_idle,
        miss_mem_wait,
        miss_evict,
        miss_fill,
        miss_replay
    } miss_state_t;

endpackage

/* icache_fetch_stage.sv */
/*
 * Stage one of the instruction cache
 *   captures a CPU fetch strobe and its address
 *   splits the address into line address and word select
 *   holds its contents while the cache is stalled
 */
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_fetch_stage (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_valid,
    input  icache_addr_pkg::fetch_addr_t req_addr,
    input  logic                         stall,
    output logic                         s1_valid,
    output icache_pipe_pkg::fetch_req_t  s1_req
);
    import icache_pipe_pkg::*;

    localparam int ADDR_MSB = `ICACHE_TAG_W + `ICACHE_INDEX_W + `ICACHE_OFFSET_W - 1;
    localparam int SEL_LSB  = `ICACHE_OFFSET_W - `ICACHE_WORD_SEL_W;

    fetch_req_t req_split;

    // byte bits below the word select are dropped here
    assign req_split.line_addr = req_addr[ADDR_MSB:`ICACHE_OFFSET_W];
    assign req_split.word_sel  = req_addr[`ICACHE_OFFSET_W-1:SEL_LSB];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req_valid;
        end
    end

    // payload only moves when the pipe advances
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_req <= req_split;
        end
    end

endmodule

/* icache_line_array.sv */
/*
 * Stage two of the instruction cache
 *   direct mapped tag, valid and data store
 *   registered set read, request follows its set
 *   refill write with same-edge forwarding into the read register
 */
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_line_array (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        s1_valid,
    input  icache_pipe_pkg::fetch_req_t s1_req,
    input  logic                        stall,
    input  logic                        fill_en,
    input  icache_addr_pkg::index_t     fill_index,
    input  icache_addr_pkg::tag_t       fill_tag,
    input  icache_addr_pkg::line_t      fill_line,
    output logic                        s2_valid,
    output icache_pipe_pkg::fetch_req_t s2_req,
    output icache_pipe_pkg::array_rd_t  s2_rd
);
    import icache_addr_pkg::*;
    import icache_pipe_pkg::*;

    tag_t                    tag_mem  [`ICACHE_SETS];
    line_t                   data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_bits;

    fetch_req_t rd_req;
    index_t     rd_index;

    // while stalled the held request indexes the store again
    assign rd_req   = stall ? s2_req : s1_req;
    assign rd_index = rd_req.line_addr[`ICACHE_INDEX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s2_req <= s1_req;
        end
    end

    // a fill to the set being read shows up on the same edge
    always_ff @(posedge clk) begin
        if (fill_en && (fill_index == rd_index)) begin
            s2_rd.tag   <= fill_tag;
            s2_rd.valid <= 1'b1;
            s2_rd.line  <= fill_line;
        end else begin
            s2_rd.tag   <= tag_mem[rd_index];
            s2_rd.valid <= valid_bits[rd_index];
            s2_rd.line  <= data_mem[rd_index];
        end
    end

endmodule

/* victim_icache.sv */
/*
 * Victim buffer behind the main instruction store
 *   fully associative, one valid bit per entry
 *   combinational lookup, lowest matching entry wins
 *   write on the registered rising edge of we
 *   wrapping counter picks the entry to replace
 */
`timescale 1ns/10ps
`include "icache_config.svh"

module victim_icache #(
    parameter int TAG_WIDTH   = `ICACHE_TAG_W,
    parameter int INDEX_WIDTH = `ICACHE_INDEX_W
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  icache_addr_pkg::line_addr_t r_tag,
    output logic                        victim_hit,
    output icache_addr_pkg::line_t      data_out,
    input  icache_addr_pkg::line_addr_t w_tag,
    input  logic                        we,
    input  icache_addr_pkg::line_t      data_in
);
    import icache_addr_pkg::*;

    localparam int KEY_W = TAG_WIDTH + INDEX_WIDTH;
    localparam int DEPTH = `ICACHE_VICTIM_DEPTH;
    localparam int CNT_W = $clog2(DEPTH);

    logic [KEY_W-1:0] key_mem  [DEPTH];
    line_t            data_mem [DEPTH];
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] match;
    logic [CNT_W-1:0] hit_sel;
    logic [CNT_W-1:0] wr_ptr;
    logic             we_d1;
    logic             we_d2;
    logic             wr_pulse;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            match[i] = entry_valid[i] && (key_mem[i] == r_tag[KEY_W-1:0]);
        end
    end

    // scan from the top so the lowest match is kept
    always_comb begin
        hit_sel = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_sel = CNT_W'(i);
            end
        end
    end

    assign victim_hit = |match;
    assign data_out   = victim_hit ? data_mem[hit_sel] : '0;

    // rising edge of the write level, seen one edge late
    always_ff @(posedge clk) begin
        if (!rstn) begin
            we_d1 <= 1'b0;
            we_d2 <= 1'b0;
        end else begin
            we_d1 <= we;
            we_d2 <= we_d1;
        end
    end

    assign wr_pulse = we_d1 && !we_d2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            entry_valid <= '0;
            wr_ptr      <= '0;
        end else if (wr_pulse) begin
            entry_valid[wr_ptr] <= 1'b1;
            wr_ptr              <= wr_ptr + 1'b1;
        end
    end

    // oldest entry goes first
    always_ff @(posedge clk) begin
        if (wr_pulse) begin
            key_mem[wr_ptr]  <= w_tag[KEY_W-1:0];
            data_mem[wr_ptr] <= data_in;
        end
    end

endmodule

/* icache_hit_stage.sv */
/*
 * Stage three of the instruction cache
 *   tag compare against main store and victim buffer
 *   word select and registered response
 *   miss FSM: memory request, eviction to the victim buffer,
 *   main store fill and replay of the lookup
 *   stall/busy generation for the whole pipe
 */
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_hit_stage (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        s2_valid,
    input  icache_pipe_pkg::fetch_req_t s2_req,
    input  icache_pipe_pkg::array_rd_t  s2_rd,
    input  logic                        victim_hit,
    input  icache_addr_pkg::line_t      victim_line,
    output logic                        stall,
    output logic                        victim_we,
    output icache_addr_pkg::line_addr_t victim_w_addr,
    output icache_addr_pkg::line_t      victim_w_line,
    output logic                        fill_en,
    output icache_addr_pkg::index_t     fill_index,
    output icache_addr_pkg::tag_t       fill_tag,
    output icache_addr_pkg::line_t      fill_line,
    output logic                        mem_req,
    output icache_addr_pkg::line_addr_t mem_line_addr,
    input  logic                        mem_valid,
    input  icache_addr_pkg::line_t      mem_line,
    output logic                        resp_valid,
    output icache_addr_pkg::word_t      resp_data,
    output logic                        busy
);
    import icache_addr_pkg::*;
    import icache_pipe_pkg::*;

    localparam int WORD_W = `ICACHE_WORD_W;

    miss_state_t state;
    logic        evict_cnt;
    line_t       line_buf;
    tag_t        req_tag;
    index_t      req_index;
    line_t       sel_line;
    logic        main_hit;
    logic        any_hit;
    logic        lookup;
    logic        miss;

    assign req_tag   = s2_req.line_addr[`ICACHE_INDEX_W +: `ICACHE_TAG_W];
    assign req_index = s2_req.line_addr[`ICACHE_INDEX_W-1:0];

    assign main_hit = s2_rd.valid && (s2_rd.tag == req_tag);
    assign any_hit  = main_hit || victim_hit;
    assign sel_line = main_hit ? s2_rd.line : victim_line;

    // compare only in idle or on the replayed lookup
    assign lookup = s2_valid && ((state == miss_idle) || (state == miss_replay));
    assign miss   = lookup && !any_hit;

    assign stall = (state == miss_mem_wait) || (state == miss_evict)
                || (state == miss_fill) || miss;
    assign busy  = stall;

    // old main line goes to the victim buffer
    assign victim_we     = (state == miss_evict);
    assign victim_w_addr = {s2_rd.tag, req_index};
    assign victim_w_line = s2_rd.line;

    assign fill_en    = (state == miss_fill);
    assign fill_index = req_index;
    assign fill_tag   = req_tag;
    assign fill_line  = line_buf;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= miss_idle;
            evict_cnt <= 1'b0;
            mem_req   <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                miss_idle, miss_replay: begin
                    if (miss) begin
                        state   <= miss_mem_wait;
                        mem_req <= 1'b1;
                    end else begin
                        state <= miss_idle;
                    end
                end
                miss_mem_wait: begin
                    if (mem_valid) begin
                        state <= s2_rd.valid ? miss_evict : miss_fill;
                    end
                end
                // write level held for two cycles
                miss_evict: begin
                    evict_cnt <= !evict_cnt;
                    if (evict_cnt) begin
                        state <= miss_fill;
                    end
                end
                miss_fill: begin
                    state <= miss_replay;
                end
                default: begin
                    state <= miss_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            mem_line_addr <= s2_req.line_addr;
        end
        if ((state == miss_mem_wait) && mem_valid) begin
            line_buf <= mem_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= lookup && any_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && any_hit) begin
            resp_data <= sel_line[s2_req.word_sel*WORD_W +: WORD_W];
        end
    end

endmodule

/* icache_top.sv */
/*
 * Instruction cache top level
 *   fetch stage, line array and hit stage in a three-stage pipe
 *   victim buffer beside the hit stage
 *   CPU strobe/busy port and memory line port
 */
`timescale 1ns/10ps
`include "icache_config.svh"

module icache_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_valid,
    input  icache_addr_pkg::fetch_addr_t req_addr,
    output logic                         busy,
    output logic                         resp_valid,
    output icache_addr_pkg::word_t       resp_data,
    output logic                         mem_req,
    output icache_addr_pkg::line_addr_t  mem_line_addr,
    input  logic                         mem_valid,
    input  icache_addr_pkg::line_t       mem_line
);
    import icache_addr_pkg::*;
    import icache_pipe_pkg::*;

    logic       stall;
    logic       s1_valid;
    fetch_req_t s1_req;
    logic       s2_valid;
    fetch_req_t s2_req;
    array_rd_t  s2_rd;

    logic       fill_en;
    index_t     fill_index;
    tag_t       fill_tag;
    line_t      fill_line;

    logic       victim_hit;
    line_t      victim_line;
    logic       victim_we;
    line_addr_t victim_w_addr;
    line_t      victim_w_line;

    icache_fetch_stage u_fetch (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .stall     (stall),
        .s1_valid  (s1_valid),
        .s1_req    (s1_req)
    );

    icache_line_array u_array (
        .clk        (clk),
        .rstn       (rstn),
        .s1_valid   (s1_valid),
        .s1_req     (s1_req),
        .stall      (stall),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .s2_valid   (s2_valid),
        .s2_req     (s2_req),
        .s2_rd      (s2_rd)
    );

    // looked up with the stage-two line address
    victim_icache #(
        .TAG_WIDTH   (`ICACHE_TAG_W),
        .INDEX_WIDTH (`ICACHE_INDEX_W)
    ) u_victim (
        .clk        (clk),
        .rstn       (rstn),
        .r_tag      (s2_req.line_addr),
        .victim_hit (victim_hit),
        .data_out   (victim_line),
        .w_tag      (victim_w_addr),
        .we         (victim_we),
        .data_in    (victim_w_line)
    );

    icache_hit_stage u_hit (
        .clk           (clk),
        .rstn          (rstn),
        .s2_valid      (s2_valid),
        .s2_req        (s2_req),
        .s2_rd         (s2_rd),
        .victim_hit    (victim_hit),
        .victim_line   (victim_line),
        .stall         (stall),
        .victim_we     (victim_we),
        .victim_w_addr (victim_w_addr),
        .victim_w_line (victim_w_line),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .mem_req       (mem_req),
        .mem_line_addr (mem_line_addr),
        .mem_valid     (mem_valid),
        .mem_line      (mem_line),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .busy          (busy)
    );

endmodule

/* tb_icache.sv */
/*
 * Testbench for the instruction cache
 *   clock, reset and line-based memory model
 *   stimulus table applied in a loop, responses checked in order
 *   typed compare tasks for words, line addresses, refill and levels
 */
`timescale 1ns/10ps
`include "icache_config.svh"

module tb_icache;
    import icache_addr_pkg::*;

    localparam int WORDS      = `ICACHE_LINE_W / `ICACHE_WORD_W;
    localparam int MAX_ROWS   = 32;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        fetch_addr_t addr;
        logic        refill;
        logic        b2b;
    } stim_row_t;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    fetch_addr_t req_addr;
    logic        busy;
    logic        resp_valid;
    word_t       resp_data;
    logic        mem_req;
    line_addr_t  mem_line_addr;
    logic        mem_valid;
    line_t       mem_line;

    stim_row_t   rows [MAX_ROWS];
    string       row_name [MAX_ROWS];
    int          row_cnt;
    int          expect_q [$];
    logic        refill_seen;
    logic        mem_wait_open;

    // sets that already hold a line, so a refill there evicts
    logic [`ICACHE_SETS-1:0] set_filled;
    logic        post_open;
    int          post_cnt;
    int          post_len;

    logic        mem_pending;
    line_addr_t  mem_addr_hold;
    int          mem_delay;

    icache_top uut (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .busy          (busy),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .mem_req       (mem_req),
        .mem_line_addr (mem_line_addr),
        .mem_valid     (mem_valid),
        .mem_line      (mem_line)
    );

    always #50 clk = ~clk;

    // expected data: word w of line L is (L << 4) + w
    function automatic word_t word_of(input line_addr_t l, input word_sel_t w);
        return (word_t'(l) << 4) + word_t'(w);
    endfunction

    function automatic line_addr_t line_of(input fetch_addr_t a);
        return line_addr_t'(a >> `ICACHE_OFFSET_W);
    endfunction

    function automatic word_t expected_word(input fetch_addr_t a);
        return word_of(line_of(a), word_sel_t'(a >> 2));
    endfunction

    function automatic line_t make_line(input line_addr_t l);
        line_t data;
        data = '0;
        for (int w = 0; w < WORDS; w++) begin
            data[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = word_of(l, word_sel_t'(w));
        end
        return data;
    endfunction

    function automatic fetch_addr_t make_addr(input tag_t t, input index_t i,
                                              input word_sel_t w);
        return {t, i, w, 2'b00};
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_line_addr(input string name, input line_addr_t exp,
                                   input line_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s line address: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_refill(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s refill: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_row(input string name, input fetch_addr_t addr,
                           input logic refill, input logic b2b);
        row_name[row_cnt] = name;
        rows[row_cnt]     = '{addr: addr, refill: refill, b2b: b2b};
        row_cnt++;
    endtask

    task automatic wait_drained(input string name);
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0) begin
            if (cycles == WAIT_LIMIT) begin
                stop_run({"timeout waiting for responses before ", name});
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    task automatic wait_not_busy(input string name);
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles == WAIT_LIMIT) begin
                stop_run({"timeout waiting for busy to fall before ", name});
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    // memory answers 1 to 8 cycles after its request
    always begin
        @(posedge clk);
        #1;
        mem_valid = 1'b0;
        if (mem_pending) begin
            if (mem_delay == 0) begin
                mem_valid   = 1'b1;
                mem_line    = make_line(mem_addr_hold);
                mem_pending = 1'b0;
            end else begin
                mem_delay--;
            end
        end
        if (mem_req) begin
            if (mem_pending) begin
                stop_run("memory request while a line is still pending");
            end
            mem_pending   = 1'b1;
            mem_addr_hold = mem_line_addr;
            mem_delay     = $urandom % 8;
        end
    end

    // responses and memory requests belong to the oldest open request
    always @(negedge clk) begin : monitor
        int     head;
        index_t idx;
        if (rstn) begin
            // evict and fill keep busy high, replay drops it, then the response
            if (post_open) begin
                post_cnt++;
                if (post_cnt <= post_len) begin
                    check_flag({row_name[expect_q[0]], " busy during refill"}, 1'b1, busy);
                end else if (post_cnt == post_len + 1) begin
                    check_flag({row_name[expect_q[0]], " busy at replay"}, 1'b0, busy);
                end else begin
                    check_flag({row_name[expect_q[0]], " response after refill"},
                               1'b1, resp_valid);
                    post_open = 1'b0;
                end
            end
            if (mem_req) begin
                if (expect_q.size() == 0) begin
                    stop_run("memory request with no fetch outstanding");
                end
                head = expect_q[0];
                if (!rows[head].refill || refill_seen) begin
                    stop_run({"memory request not expected for ", row_name[head]});
                end
                check_line_addr(row_name[head], line_of(rows[head].addr), mem_line_addr);
                refill_seen   = 1'b1;
                mem_wait_open = 1'b1;
            end
            if (mem_wait_open) begin
                check_flag({row_name[expect_q[0]], " busy during miss"}, 1'b1, busy);
                if (mem_valid) begin
                    mem_wait_open = 1'b0;
                    idx           = index_t'(line_of(rows[expect_q[0]].addr));
                    post_len      = set_filled[idx] ? 3 : 1;
                    set_filled[idx] = 1'b1;
                    post_cnt      = 0;
                    post_open     = 1'b1;
                end
            end
            if (resp_valid) begin
                if (expect_q.size() == 0) begin
                    stop_run("response with no fetch outstanding");
                end
                head = expect_q.pop_front();
                check_refill(row_name[head], rows[head].refill, refill_seen);
                check_word(row_name[head], expected_word(rows[head].addr), resp_data);
                refill_seen = 1'b0;
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        req_valid     = 1'b0;
        req_addr      = '0;
        mem_valid     = 1'b0;
        mem_line      = '0;
        mem_pending   = 1'b0;
        mem_addr_hold = '0;
        mem_delay     = 0;
        refill_seen   = 1'b0;
        mem_wait_open = 1'b0;
        set_filled    = '0;
        post_open     = 1'b0;
        post_cnt      = 0;
        post_len      = 0;
        row_cnt       = 0;
        void'($urandom(32'h1748_7db9));

        // same-index pairs, then a chain of five evictions at index 9
        add_row("cold_miss",       make_addr(20'h1, 6'd5, 4'd3), 1'b1, 1'b0);
        add_row("same_line_hit",   make_addr(20'h1, 6'd5, 4'd10) | 32'h3, 1'b0, 1'b0);
        add_row("conflict_evict",  make_addr(20'h2, 6'd5, 4'd0), 1'b1, 1'b0);
        add_row("victim_return",   make_addr(20'h1, 6'd5, 4'd7), 1'b0, 1'b0);
        add_row("chain_fill_0",    make_addr(20'h10, 6'd9, 4'd0), 1'b1, 1'b0);
        add_row("chain_evict_1",   make_addr(20'h11, 6'd9, 4'd1), 1'b1, 1'b0);
        add_row("chain_evict_2",   make_addr(20'h12, 6'd9, 4'd2), 1'b1, 1'b0);
        add_row("chain_evict_3",   make_addr(20'h13, 6'd9, 4'd3), 1'b1, 1'b0);
        add_row("chain_evict_4",   make_addr(20'h14, 6'd9, 4'd4), 1'b1, 1'b0);
        add_row("chain_evict_5",   make_addr(20'h15, 6'd9, 4'd5), 1'b1, 1'b0);
        add_row("victim_keep_11",  make_addr(20'h11, 6'd9, 4'd6), 1'b0, 1'b0);
        add_row("victim_keep_12",  make_addr(20'h12, 6'd9, 4'd7), 1'b0, 1'b0);
        add_row("victim_keep_13",  make_addr(20'h13, 6'd9, 4'd8), 1'b0, 1'b0);
        add_row("victim_keep_14",  make_addr(20'h14, 6'd9, 4'd9), 1'b0, 1'b0);
        add_row("oldest_refill",   make_addr(20'h10, 6'd9, 4'd10), 1'b1, 1'b0);
        // hits strobed on consecutive cycles
        add_row("burst_0",         make_addr(20'h10, 6'd9, 4'd1), 1'b0, 1'b0);
        add_row("burst_1",         make_addr(20'h10, 6'd9, 4'd2), 1'b0, 1'b1);
        add_row("burst_2",         make_addr(20'h2, 6'd5, 4'd4), 1'b0, 1'b1);
        add_row("burst_3",         make_addr(20'h13, 6'd9, 4'd5), 1'b0, 1'b1);
        // a hit queued right behind a miss
        add_row("miss_cold",       make_addr(20'h30, 6'd12, 4'd6), 1'b1, 1'b0);
        add_row("hit_behind_cold", make_addr(20'h2, 6'd5, 4'd9), 1'b0, 1'b1);
        add_row("miss_evict",      make_addr(20'h31, 6'd12, 4'd11), 1'b1, 1'b0);
        add_row("hit_behind_evict", make_addr(20'h10, 6'd9, 4'd15), 1'b0, 1'b1);
        add_row("victim_after",    make_addr(20'h30, 6'd12, 4'd0), 1'b0, 1'b0);

        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;

        // quiet outputs with no request
        repeat (4) begin
            @(negedge clk);
            check_flag("idle resp_valid", 1'b0, resp_valid);
            check_flag("idle mem_req", 1'b0, mem_req);
            check_flag("idle busy", 1'b0, busy);
        end
        @(posedge clk);
        #1;

        for (int r = 0; r < row_cnt; r++) begin
            if (!rows[r].b2b) begin
                wait_drained(row_name[r]);
            end
            wait_not_busy(row_name[r]);
            req_valid = 1'b1;
            req_addr  = rows[r].addr;
            expect_q.push_back(r);
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end

        wait_drained("end of run");
        repeat (6) @(posedge clk);
        #1;

        if (expect_q.size() == 0 && !busy) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

/* src.f */
+incdir+.
icache_addr_pkg.sv
icache_pipe_pkg.sv
icache_fetch_stage.sv
icache_line_array.sv
victim_icache.sv
icache_hit_stage.sv
icache_top.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_icache -f src.f -o sim_icache &&
./obj_dir/sim_icache ||
exit 1
